//--- hw/apbRegs.sv
`timescale 1ns/1ps
/*
 * apbRegs: APB register block. Stages code words into code memory, holds
 * the program length, issues start and serves status and out reads.
 */
module apbRegs
  import isaPkg::*;
  import busPkg::*;
#(
  parameter int OutDepth = 4
) (
  input  logic                          clock,
  input  logic                          rstN,
  input  apbReqT                        apbReq,
  output apbRspT                        apbRsp,
  output codeWriteT                     codeWrite,
  output logic                          start,
  output codeAddrT                      length,
  input  logic                          running,
  input  logic                          finished,
  input  logic [$clog2(OutDepth+1)-1:0] outCount,
  input  wordT                          outHead,
  output logic                          outPop
);

  logic        access;
  logic        wrAccess;
  logic        rdAccess;
  logic        mapped;
  logic        lockedReg;                      // written only while idle
  logic        outEmpty;
  codeAddrT    codeIndex;
  logic [31:0] codeLo;
  statusT      status;

  assign access   = apbReq.psel & apbReq.penable;
  assign wrAccess = access & apbReq.pwrite;
  assign rdAccess = access & ~apbReq.pwrite;
  assign outEmpty = (outCount == '0);

  always_comb begin
    mapped    = 1'b1;
    lockedReg = 1'b0;
    case (apbReq.paddr)
      regCtrl, regCodeAddr, regCodeLo, regCodeHi, regLength: lockedReg = 1'b1;
      regStatus, regOut: ;
      default: mapped = 1'b0;
    endcase
  end

  // --------------------------------------------------------------------------
  // response, no wait states
  // --------------------------------------------------------------------------
  always_comb begin
    status          = '0;
    status.running  = running;
    status.finished = finished;
    status.count    = 8'(outCount);

    apbRsp.pready  = 1'b1;
    apbRsp.pslverr = access & (~mapped | (wrAccess & lockedReg & running) |
                     (rdAccess & (apbReq.paddr == regOut) & outEmpty));
    case (apbReq.paddr)
      regStatus:   apbRsp.prdata = status;
      regCodeAddr: apbRsp.prdata = 32'(codeIndex);
      regCodeLo:   apbRsp.prdata = codeLo;
      regLength:   apbRsp.prdata = 32'(length);
      regOut:      apbRsp.prdata = outEmpty ? '0 : 32'(outHead); // sign extended
      default:     apbRsp.prdata = '0;
    endcase
  end

  assign start  = wrAccess & (apbReq.paddr == regCtrl) & apbReq.pwdata[0] & ~running;
  assign outPop = rdAccess & (apbReq.paddr == regOut) & ~outEmpty;

  assign codeWrite.enable      = wrAccess & (apbReq.paddr == regCodeHi) & ~running;
  assign codeWrite.address     = codeIndex;
  assign codeWrite.instruction = instructionT'({apbReq.pwdata[23:0], codeLo});

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      codeIndex <= '0;
      length    <= '0;
    end else if (wrAccess && !running) begin
      case (apbReq.paddr)
        regCodeAddr: codeIndex <= apbReq.pwdata[7:0];
        regCodeHi:   codeIndex <= codeIndex + 8'd1;  // next slot
        regLength:   length    <= apbReq.pwdata[7:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (wrAccess && !running && apbReq.paddr == regCodeLo) begin
      codeLo <= apbReq.pwdata;                 // low half of the next word
    end
  end

endmodule

//--- hw/busPkg.sv
/*
 * busPkg: APB slave port of the test processor. Request and response
 * structs, register map, status word layout and the code write record.
 */
package busPkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apbReqT;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apbRspT;

  // register map
  localparam logic [7:0] regCtrl     = 8'h00;  // bit 0 starts a run
  localparam logic [7:0] regStatus   = 8'h04;
  localparam logic [7:0] regCodeAddr = 8'h08;
  localparam logic [7:0] regCodeLo   = 8'h0C;  // instruction bits 31:0
  localparam logic [7:0] regCodeHi   = 8'h10;  // bits 55:32, commits the word
  localparam logic [7:0] regLength   = 8'h14;
  localparam logic [7:0] regOut      = 8'h18;  // read pops the out FIFO

  typedef struct packed {
    logic [15:0] reserved;
    logic [7:0]  count;                        // words waiting in the out FIFO
    logic [5:0]  spare;
    logic        finished;
    logic        running;
  } statusT;

  typedef struct packed {
    logic                enable;
    isaPkg::codeAddrT    address;
    isaPkg::instructionT instruction;
  } codeWriteT;

endpackage

//--- hw/executeUnit.sv
`timescale 1ns/1ps
/*
 * executeUnit: combinational datapath. Turns resolved operands into a
 * memory write, a branch decision or an out push.
 */
module executeUnit
  import isaPkg::*;
(
  input  logic              running,
  input  logic              fire,
  input  instructionT       instruction,
  input  resolvedT          resolved,
  output writeT             write,
  output logic              branchTaken,
  output logic signed [7:0] branchOffset,
  output logic              outPush,
  output wordT              outValue
);

  logic go;
  logic doWrite;
  logic taken;
  logic doOut;
  wordT result;
  wordT a;
  wordT b;

  assign go = running & fire;
  assign a  = resolved.source1Value;
  assign b  = resolved.source2Value;

  always_comb begin
    result  = '0;
    doWrite = 1'b0;
    taken   = 1'b0;
    doOut   = 1'b0;
    case (instruction.operator)
      opAdd:      begin result = a + b; doWrite = 1'b1; end // 12 bit wrap
      opSubtract: begin result = a - b; doWrite = 1'b1; end
      opMov:      begin result = a;     doWrite = 1'b1; end
      opNot:      begin result = (a == '0) ? wordT'(1) : '0; doWrite = 1'b1; end
      opOut:      doOut = 1'b1;
      opJmp:      taken = 1'b1;
      opJEq:      taken = (a == b);
      opJNe:      taken = (a != b);
      opJLt:      taken = (a < b);             // signed compare
      opJGe:      taken = (a >= b);
      default: ;                               // everything else is a nop
    endcase
  end

  assign write.enable   = go & doWrite & (resolved.targetArena != arenaNone);
  assign write.arena    = resolved.targetArena;
  assign write.location = resolved.targetLocation;
  assign write.value    = result;

  assign branchTaken  = go & taken;
  assign branchOffset = instruction.target.address;
  assign outPush      = go & doOut;
  assign outValue     = a;

endmodule

//--- hw/isaPkg.sv
/*
 * isaPkg: instruction set of the test processor. Holds the instruction and
 * operand layout, the opcodes, arenas, addressing modes and data word types.
 */
package isaPkg;

  // --------------------------------------------------------------------------
  // widths that carry a meaning
  // --------------------------------------------------------------------------
  typedef logic signed [11:0] wordT;           // memory element
  typedef logic [7:0]         codeAddrT;       // code memory index
  typedef logic [3:0]         localAddrT;      // local memory index
  typedef logic [4:0]         heapAddrT;       // area * NArea + address

  typedef enum logic [7:0] {
    opAdd      = 8'd0,
    opSubtract = 8'd1,
    opMov      = 8'd2,
    opNot      = 8'd3,
    opOut      = 8'd4,
    opJmp      = 8'd5,
    opJEq      = 8'd6,
    opJNe      = 8'd7,
    opJLt      = 8'd8,
    opJGe      = 8'd9,
    opNop      = 8'd10                         // any other code also does nothing
  } opcodeT;

  typedef enum logic [1:0] {
    arenaNone  = 2'd0,
    arenaHeap  = 2'd1,
    arenaLocal = 2'd2
  } arenaT;

  typedef enum logic [1:0] {
    modeImmediate = 2'd0,
    modeDirect    = 2'd1,
    modeIndirect  = 2'd2
  } modeT;

  // --------------------------------------------------------------------------
  // instruction layout, 8 + 3 * 16 bits
  // --------------------------------------------------------------------------
  typedef struct packed {
    arenaT              arena;
    modeT               mode;
    logic [3:0]         area;                  // heap area number
    logic signed [7:0]  address;               // also immediate or jump offset
  } operandT;

  typedef struct packed {
    opcodeT  operator;
    operandT target;
    operandT source1;
    operandT source2;
  } instructionT;

  typedef struct packed {
    wordT     source1Value;
    wordT     source2Value;
    arenaT    targetArena;
    heapAddrT targetLocation;                  // local index in the low bits
  } resolvedT;

  typedef struct packed {
    logic     enable;
    arenaT    arena;
    heapAddrT location;
    wordT     value;
  } writeT;

endpackage

//--- hw/operandMemory.sv
`timescale 1ns/1ps
/*
 * operandMemory: local and heap memories of the test processor. Resolves
 * the three operands of the current instruction and writes back results.
 */
module operandMemory
  import isaPkg::*;
#(
  parameter int NLocal  = 16,
  parameter int NArea   = 8,
  parameter int NArrays = 4
) (
  input  logic        clock,
  input  logic        rstN,
  input  logic        start,
  input  instructionT instruction,
  input  writeT       write,
  output resolvedT    resolved
);

  localparam int NHeap = NArea * NArrays;

  wordT localMem [NLocal];
  wordT heapMem  [NHeap];

  // --------------------------------------------------------------------------
  // operand resolution
  // --------------------------------------------------------------------------

  // location of a direct or indirect operand
  function automatic heapAddrT operandLocation(operandT op);
    logic [7:0] index;
    int         base;
    if (op.mode == modeIndirect) begin
      index = localMem[localAddrT'(op.address)][7:0]; // address held in local
    end else begin
      index = op.address;
    end
    if (op.arena == arenaHeap) begin
      base = int'(op.area) * NArea + int'(index);
    end else begin
      base = int'(index);
    end
    return heapAddrT'(base);
  endfunction

  function automatic wordT operandValue(operandT op);
    heapAddrT location;
    wordT     value;
    location = operandLocation(op);
    if (op.mode == modeImmediate) begin
      value = wordT'(op.address);              // sign extended constant
    end else begin
      case (op.arena)
        arenaHeap:  value = heapMem[location];
        arenaLocal: value = localMem[localAddrT'(location)];
        default:    value = '0;
      endcase
    end
    if (op.arena == arenaNone) begin
      value = '0;                              // unused operand
    end
    return value;
  endfunction

  always_comb begin
    resolved.source1Value   = operandValue(instruction.source1);
    resolved.source2Value   = operandValue(instruction.source2);
    resolved.targetArena    = instruction.target.arena;
    resolved.targetLocation = operandLocation(instruction.target);
  end

  // --------------------------------------------------------------------------
  // write back, both memories cleared at the start of a run
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < NLocal; i++) begin
        localMem[i] <= '0;
      end
      for (int i = 0; i < NHeap; i++) begin
        heapMem[i] <= '0;
      end
    end else if (start) begin
      for (int i = 0; i < NLocal; i++) begin
        localMem[i] <= '0;
      end
      for (int i = 0; i < NHeap; i++) begin
        heapMem[i] <= '0;
      end
    end else if (write.enable) begin
      case (write.arena)
        arenaHeap:  heapMem[write.location] <= write.value;
        arenaLocal: localMem[localAddrT'(write.location)] <= write.value;
        default: ;
      endcase
    end
  end

endmodule

//--- hw/outChannel.sv
`timescale 1ns/1ps
/*
 * outChannel: FIFO of out values, read by the host through regOut.
 * Reports its fill count and full for back-pressure.
 */
module outChannel
  import isaPkg::*;
#(
  parameter int OutDepth = 4
) (
  input  logic                          clock,
  input  logic                          rstN,
  input  logic                          start,
  input  logic                          push,
  input  wordT                          value,
  input  logic                          pop,
  output logic [$clog2(OutDepth+1)-1:0] count,
  output wordT                          head,
  output logic                          full
);

  localparam int PtrW   = (OutDepth > 1) ? $clog2(OutDepth) : 1;
  localparam int CountW = $clog2(OutDepth + 1);

  wordT            fifo [OutDepth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic            doPush;
  logic            doPop;

  function automatic logic [PtrW-1:0] bump(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(OutDepth - 1)) ? '0 : ptr + PtrW'(1);
  endfunction

  assign full   = (count == OutDepth);
  assign head   = fifo[rdPtr];
  assign doPush = push & ~full;
  assign doPop  = pop & (count != '0);

  always_ff @(posedge clock) begin
    if (doPush) fifo[wrPtr] <= value;
  end

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else if (start) begin
      wrPtr <= '0;                             // new run, drop old values
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= bump(wrPtr);
      if (doPop) rdPtr <= bump(rdPtr);
      case ({doPush, doPop})
        2'b10:   count <= count + CountW'(1);
        2'b01:   count <= count - CountW'(1);
        default: ;
      endcase
    end
  end

endmodule

//--- hw/programSequencer.sv
`timescale 1ns/1ps
/*
 * programSequencer: code memory, instruction pointer and run control.
 * Executes one instruction per cycle and stalls out on a full FIFO.
 */
module programSequencer
  import isaPkg::*;
  import busPkg::*;
#(
  parameter int NInstructions = 64
) (
  input  logic              clock,
  input  logic              rstN,
  input  codeWriteT         codeWrite,
  input  logic              start,
  input  codeAddrT          length,
  input  logic              outFull,
  input  logic              branchTaken,
  input  logic signed [7:0] branchOffset,
  output instructionT       instruction,
  output logic              fire,
  output logic              running,
  output logic              finished
);

  localparam int IdxW = $clog2(NInstructions);

  typedef enum logic [1:0] {
    stIdle,
    stRun,
    stDone
  } stateT;

  stateT             state;
  instructionT       code [NInstructions];
  logic signed [9:0] ip;                       // room for jumps out of range
  logic signed [9:0] nextIp;
  logic              inRange;
  logic              stall;

  always_ff @(posedge clock) begin
    if (codeWrite.enable && codeWrite.address < NInstructions) begin
      code[codeWrite.address[IdxW-1:0]] <= codeWrite.instruction;
    end
  end

  // --------------------------------------------------------------------------
  // fetch and issue
  // --------------------------------------------------------------------------
  assign instruction = code[ip[IdxW-1:0]];
  assign inRange     = (ip >= 0) && (ip < $signed({2'b00, length})) &&
                       (ip < NInstructions);
  assign stall       = (instruction.operator == opOut) && outFull;
  assign fire        = running && inRange && !stall;
  assign nextIp      = branchTaken ? ip + 10'(branchOffset) : ip + 10'sd1;

  assign running  = (state == stRun);
  assign finished = (state == stDone);

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state <= stIdle;
      ip    <= '0;
    end else if (start) begin
      state <= stRun;
      ip    <= '0;
    end else begin
      case (state)
        stRun: begin
          if (!inRange) begin
            state <= stDone;                   // ip left the program
          end else if (fire) begin
            ip <= nextIp;
          end
        end
        default: ;                             // idle and done wait for start
      endcase
    end
  end

endmodule

//--- hw/testProcessor.sv
`timescale 1ns/1ps
/*
 * testProcessor: top level of the test program processor. Connects the
 * APB registers, sequencer, operand memory, execute unit and out FIFO.
 */
module testProcessor
  import isaPkg::*;
  import busPkg::*;
#(
  parameter int NInstructions = 64,
  parameter int NLocal        = 16,
  parameter int NArea         = 8,
  parameter int NArrays       = 4,             // heap of NArea * NArrays
  parameter int OutDepth      = 4
) (
  input  logic   clock,
  input  logic   rstN,
  input  apbReqT apbReq,
  output apbRspT apbRsp
);

  localparam int CountW = $clog2(OutDepth + 1);

  codeWriteT         codeWrite;
  logic              start;
  codeAddrT          length;
  logic              running;
  logic              finished;
  logic [CountW-1:0] outCount;
  wordT              outHead;
  logic              outPop;
  logic              outFull;
  instructionT       instruction;
  logic              fire;
  resolvedT          resolved;
  writeT             write;
  logic              branchTaken;
  logic signed [7:0] branchOffset;
  logic              outPush;
  wordT              outValue;

  apbRegs #(.OutDepth(OutDepth)) i_apbRegs (
    .clock, .rstN, .apbReq, .apbRsp, .codeWrite, .start, .length,
    .running, .finished, .outCount, .outHead, .outPop
  );

  programSequencer #(.NInstructions(NInstructions)) i_programSequencer (
    .clock, .rstN, .codeWrite, .start, .length, .outFull, .branchTaken,
    .branchOffset, .instruction, .fire, .running, .finished
  );

  operandMemory #(.NLocal(NLocal), .NArea(NArea), .NArrays(NArrays)) i_operandMemory (
    .clock, .rstN, .start, .instruction, .write, .resolved
  );

  executeUnit i_executeUnit (
    .running, .fire, .instruction, .resolved, .write, .branchTaken,
    .branchOffset, .outPush, .outValue
  );

  outChannel #(.OutDepth(OutDepth)) i_outChannel (
    .clock, .rstN, .start, .push(outPush), .value(outValue), .pop(outPop),
    .count(outCount), .head(outHead), .full(outFull)
  );

endmodule

//--- list.f
hw/isaPkg.sv
hw/busPkg.sv
hw/apbRegs.sv
hw/programSequencer.sv
hw/operandMemory.sv
hw/executeUnit.sv
hw/outChannel.sv
hw/testProcessor.sv
sim/processorTb_chk.sv
sim/processorTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the test processor testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
  --top-module processorTb -f list.f -o processorSim

# the simulator exit status is not used, the log decides
./obj_dir/processorSim 2>&1 | tee sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- sim/processorTb.sv
`timescale 1ns/1ps
/*
 * processorTb: directed testbench for the test program processor. Loads
 * programs over APB, runs them and checks the out values and status.
 */
module processorTb
  import isaPkg::*;
  import busPkg::*;
();

  localparam int OutDepth  = 4;
  localparam int MaxCycles = 2000;             // about twice all tests together

  logic   clock;
  logic   rstN;
  apbReqT apbReq;
  apbRspT apbRsp;

  instructionT prog[$];                        // program of the current test
  wordT        expected[$];                    // out values still to come
  logic [31:0] rng = 32'd95;
  int          cycles = 0;

  testProcessor #(
    .NInstructions(64), .NLocal(16), .NArea(8), .NArrays(4), .OutDepth(OutDepth)
  ) i_dut (
    .clock, .rstN, .apbReq, .apbRsp
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > MaxCycles) failRun("timeout: the run did not finish in time");
  end

  // --------------------------------------------------------------------------
  // reporting and compare tasks
  // --------------------------------------------------------------------------
  task automatic failRun(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic checkWord(input string name, input wordT actual, input wordT want);
    if (actual !== want) begin
      failRun($sformatf("error at %0t ns: %s got %0d expected %0d",
                        $time, name, actual, want));
    end
  endtask

  task automatic checkStatus(input statusT actual, input statusT want);
    if (actual !== want) begin
      failRun($sformatf("error at %0t ns: status got %h expected %h",
                        $time, actual, want));
    end
  endtask

  task automatic checkError(input string name, input logic actual, input logic want);
    if (actual !== want) begin
      failRun($sformatf("error at %0t ns: %s got %b expected %b",
                        $time, name, actual, want));
    end
  endtask

  function automatic statusT makeStatus(logic run, logic fin, logic [7:0] count);
    statusT s;
    s          = '0;
    s.running  = run;
    s.finished = fin;
    s.count    = count;
    return s;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // --------------------------------------------------------------------------
  // instruction builders
  // --------------------------------------------------------------------------
  function automatic operandT immOp(int value);
    return operandT'{arena: arenaLocal, mode: modeImmediate, area: 4'd0, address: 8'(value)};
  endfunction

  function automatic operandT localOp(modeT mode, int addr);
    return operandT'{arena: arenaLocal, mode: mode, area: 4'd0, address: 8'(addr)};
  endfunction

  function automatic operandT heapOp(modeT mode, int area, int addr);
    return operandT'{arena: arenaHeap, mode: mode, area: 4'(area), address: 8'(addr)};
  endfunction

  function automatic operandT offsetOp(int offset);
    return operandT'{arena: arenaNone, mode: modeImmediate, area: 4'd0, address: 8'(offset)};
  endfunction

  function automatic instructionT makeInstr(opcodeT op, operandT t, operandT s1, operandT s2);
    return instructionT'{operator: op, target: t, source1: s1, source2: s2};
  endfunction

  // --------------------------------------------------------------------------
  // APB driver, inputs change 1 ns after the rising edge
  // --------------------------------------------------------------------------
  task automatic apbAccess(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
    apbReq.psel    = 1'b1;                     // setup phase
    apbReq.penable = 1'b0;
    apbReq.pwrite  = write;
    apbReq.paddr   = addr;
    apbReq.pwdata  = wdata;
    @(posedge clock);
    #1;
    apbReq.penable = 1'b1;                     // access phase
    @(negedge clock);
    rdata = apbRsp.prdata;
    err   = apbRsp.pslverr;
    checkError("pready", apbRsp.pready, 1'b1);
    @(posedge clock);
    #1;
    apbReq.psel    = 1'b0;
    apbReq.penable = 1'b0;
  endtask

  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apbAccess(1'b1, addr, data, unused, err);
  endtask

  task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apbAccess(1'b0, addr, '0, data, err);
  endtask

  task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
    logic err;
    apbWrite(addr, data, err);
    checkError("pslverr on write", err, 1'b0);
  endtask

  task automatic readStatus(output statusT st);
    logic [31:0] data;
    logic        err;
    apbRead(regStatus, data, err);
    checkError("pslverr on status read", err, 1'b0);
    st = statusT'(data);
  endtask

  // code words go in low half first, then the high half commits them
  task automatic loadProgram();
    writeReg(regCodeAddr, 32'd0);
    foreach (prog[i]) begin
      writeReg(regCodeLo, prog[i][31:0]);
      writeReg(regCodeHi, 32'(prog[i][55:32]));
    end
    writeReg(regLength, 32'(prog.size()));
    writeReg(regCtrl, 32'd1);
  endtask

  task automatic waitForCount(input logic [7:0] count);
    statusT st;
    readStatus(st);
    while (st.count != count) readStatus(st);
  endtask

  // read out values as they come until the run is finished and the FIFO empty
  task automatic drainOuts();
    statusT      st;
    logic [31:0] data;
    logic        err;
    logic        done;
    done = 1'b0;
    while (!done) begin
      readStatus(st);
      if (st.count != 8'd0) begin
        apbRead(regOut, data, err);
        checkError("pslverr on out read", err, 1'b0);
        if (expected.size() == 0) failRun("more out values than the program writes");
        checkWord("out value", wordT'(data[11:0]), expected.pop_front());
      end else if (st.finished) begin
        done = 1'b1;
      end
    end
    if (expected.size() != 0) failRun("run finished before all out values arrived");
    checkStatus(st, makeStatus(1'b0, 1'b1, 8'd0));
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic addTest();
    prog.delete();
    prog.push_back(makeInstr(opAdd, localOp(modeDirect, 0), immOp(2), immOp(3)));
    prog.push_back(makeInstr(opOut, offsetOp(0), localOp(modeDirect, 0), offsetOp(0)));
    expected.push_back(12'sd5);
    loadProgram();
    drainOuts();
  endtask

  task automatic addressingTest();
    prog.delete();
    prog.push_back(makeInstr(opMov, localOp(modeDirect, 3), immOp(7), offsetOp(0)));
    prog.push_back(makeInstr(opMov, localOp(modeDirect, 2), immOp(5), offsetOp(0)));
    prog.push_back(makeInstr(opMov, heapOp(modeDirect, 2, 5), immOp(-4), offsetOp(0)));
    prog.push_back(makeInstr(opMov, localOp(modeDirect, 4), immOp(3), offsetOp(0)));
    // heap 2 * 8 + local2 is heap 21, holding -4
    prog.push_back(makeInstr(opSubtract, localOp(modeDirect, 5), localOp(modeDirect, 3),
                             heapOp(modeIndirect, 2, 2)));
    prog.push_back(makeInstr(opOut, offsetOp(0), localOp(modeDirect, 5), offsetOp(0)));
    prog.push_back(makeInstr(opNot, localOp(modeDirect, 6), heapOp(modeDirect, 2, 5),
                             offsetOp(0)));
    prog.push_back(makeInstr(opOut, offsetOp(0), localOp(modeDirect, 6), offsetOp(0)));
    prog.push_back(makeInstr(opNot, localOp(modeDirect, 7), localOp(modeDirect, 0),
                             offsetOp(0)));        // local0 held 5, cleared by start
    prog.push_back(makeInstr(opOut, offsetOp(0), localOp(modeDirect, 7), offsetOp(0)));
    prog.push_back(makeInstr(opMov, heapOp(modeIndirect, 1, 4), immOp(42), offsetOp(0)));
    prog.push_back(makeInstr(opOut, offsetOp(0), heapOp(modeDirect, 1, 3), offsetOp(0)));
    prog.push_back(makeInstr(opOut, offsetOp(0), localOp(modeIndirect, 4), offsetOp(0)));
    expected = '{12'sd11, 12'sd0, 12'sd1, 12'sd42, 12'sd7};
    loadProgram();
    drainOuts();
  endtask

  task automatic branchTest();
    prog.delete();
    prog.push_back(makeInstr(opMov, localOp(modeDirect, 0), immOp(3), offsetOp(0)));
    prog.push_back(makeInstr(opOut, offsetOp(0), localOp(modeDirect, 0), offsetOp(0)));
    prog.push_back(makeInstr(opSubtract, localOp(modeDirect, 0), localOp(modeDirect, 0),
                             immOp(1)));
    prog.push_back(makeInstr(opJNe, offsetOp(-2), localOp(modeDirect, 0), immOp(0)));
    prog.push_back(makeInstr(opJmp, offsetOp(2), offsetOp(0), offsetOp(0)));
    prog.push_back(makeInstr(opOut, offsetOp(0), immOp(99), offsetOp(0))); // skipped
    prog.push_back(makeInstr(opOut, offsetOp(0), immOp(77), offsetOp(0)));
    expected = '{12'sd3, 12'sd2, 12'sd1, 12'sd77};
    loadProgram();
    drainOuts();
  endtask

  task automatic backpressureTest();
    statusT st;
    prog.delete();
    for (int i = 0; i < 6; i++) begin
      prog.push_back(makeInstr(opOut, offsetOp(0), immOp(10 + 5 * i), offsetOp(0)));
      expected.push_back(wordT'(10 + 5 * i));
    end
    loadProgram();
    waitForCount(8'(OutDepth));
    readStatus(st);
    checkStatus(st, makeStatus(1'b1, 1'b0, 8'(OutDepth)));
    repeat (5) @(posedge clock);
    #1;
    readStatus(st);
    checkStatus(st, makeStatus(1'b1, 1'b0, 8'(OutDepth))); // still stalled
    drainOuts();
  endtask

  task automatic errorTest();
    logic [31:0] data;
    logic        err;
    apbRead(regOut, data, err);                // FIFO empty after the last run
    checkError("pslverr on empty out read", err, 1'b1);
    checkWord("prdata on empty out read", wordT'(data[11:0]), '0);
    apbRead(8'h1C, data, err);
    checkError("pslverr on unmapped read", err, 1'b1);
    prog.delete();
    for (int i = 0; i < 5; i++) begin
      prog.push_back(makeInstr(opOut, offsetOp(0), immOp(21 + i), offsetOp(0)));
      expected.push_back(wordT'(21 + i));
    end
    loadProgram();
    waitForCount(8'(OutDepth));                // held running by the full FIFO
    apbWrite(regCodeLo, 32'h1234_5678, err);
    checkError("pslverr on code write while running", err, 1'b1);
    apbWrite(regCtrl, 32'd1, err);
    checkError("pslverr on ctrl write while running", err, 1'b1);
    drainOuts();
  endtask

  task automatic randomTest();
    logic signed [7:0] a;
    logic signed [7:0] b;
    wordT              sum;
    wordT              diff;
    for (int run = 0; run < 2; run++) begin
      prog.delete();
      // start near the ends of the range so the sums wrap
      prog.push_back(makeInstr(opMov, localOp(modeDirect, 0), immOp(127), offsetOp(0)));
      repeat (4) begin
        prog.push_back(makeInstr(opAdd, localOp(modeDirect, 0), localOp(modeDirect, 0),
                                 localOp(modeDirect, 0)));
      end
      prog.push_back(makeInstr(opSubtract, localOp(modeDirect, 1), immOp(0),
                               localOp(modeDirect, 0)));
      sum  = 12'sd2032;
      diff = -12'sd2032;
      for (int i = 0; i < 10; i++) begin
        rng = xorshift(rng);
        a   = rng[7:0];
        b   = rng[15:8];
        prog.push_back(makeInstr(opAdd, localOp(modeDirect, 0), localOp(modeDirect, 0),
                                 immOp(int'(a))));
        prog.push_back(makeInstr(opOut, offsetOp(0), localOp(modeDirect, 0), offsetOp(0)));
        prog.push_back(makeInstr(opSubtract, localOp(modeDirect, 1), localOp(modeDirect, 1),
                                 immOp(int'(b))));
        prog.push_back(makeInstr(opOut, offsetOp(0), localOp(modeDirect, 1), offsetOp(0)));
        sum  = sum + wordT'(a);                // 12 bit wrap
        diff = diff - wordT'(b);
        expected.push_back(sum);
        expected.push_back(diff);
      end
      loadProgram();
      drainOuts();
    end
  endtask

  initial begin
    rstN   = 1'b0;
    apbReq = '0;
    repeat (8) @(posedge clock);
    #1;
    rstN = 1'b1;
    addTest();
    addressingTest();
    branchTest();
    backpressureTest();
    errorTest();
    randomTest();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- sim/processorTb_chk.sv
`timescale 1ns/1ps
/*
 * processorTb_chk: APB and run control assertions, bound into the
 * testProcessor top level.
 */
module processorTb_chk
  import busPkg::*;
#(
  parameter int OutDepth = 4
) (
  input logic                          clock,
  input logic                          rstN,
  input apbReqT                        apbReq,
  input apbRspT                        apbRsp,
  input logic                          running,
  input logic                          finished,
  input logic [$clog2(OutDepth+1)-1:0] outCount
);

  // --------------------------------------------------------------------------
  // bus rules
  // --------------------------------------------------------------------------
  readyHigh: assert property (@(posedge clock) disable iff (!rstN) apbRsp.pready)
    else $error("pready dropped low");

  errorInAccess: assert property (@(posedge clock) disable iff (!rstN)
    apbRsp.pslverr |-> (apbReq.psel && apbReq.penable))
    else $error("pslverr outside the access phase");

  // run control and FIFO fill
  runOrDone: assert property (@(posedge clock) disable iff (!rstN) !(running && finished))
    else $error("running and finished high together");

  countBound: assert property (@(posedge clock) disable iff (!rstN) outCount <= OutDepth)
    else $error("out count above the FIFO depth");

endmodule

bind testProcessor processorTb_chk #(.OutDepth(OutDepth)) i_chk (
  .clock, .rstN, .apbReq, .apbRsp, .running, .finished, .outCount
);
